/* Makefile */
TOP = tb_spi_app

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* flist.f */
hdl/spi_app_pkg.sv
hdl/spi_msg_rx.sv
hdl/spi_ctrl.sv
hdl/spi_resp_tx.sv
hdl/cmd6_capture.sv
hdl/spi_app_top.sv
test/spi_app_assertions.sv
test/tb_spi_app.sv

/* hdl/cmd6_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd6_capture #(
    parameter int block_words     = 32,
    parameter int mode_word_index = 8
) (
    input  wire logic                        sd_datInWrite_clk,
    input  wire logic                        spi_rst_,
    input  wire logic                        datin_rst,
    input  wire logic                        datin_valid,
    input  wire spi_app_pkg::dat_word_t      datin_data,
    output spi_app_pkg::access_mode_t        access_mode,
    output logic                             block_done
);
    import spi_app_pkg::*;

    localparam int cnt_w = $clog2(block_words);
    localparam logic [cnt_w-1:0] first_cnt = cnt_w'(block_words - 1);
    localparam logic [cnt_w-1:0] mode_cnt  = cnt_w'(block_words - 1 - mode_word_index);

    logic [cnt_w-1:0] word_cnt;   // Words left in the block, minus one

    // ==================================================
    // Block word counter
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_cnt    <= first_cnt;
            access_mode <= '0;
            block_done  <= 1'b0;
        end else if (datin_rst) begin
            word_cnt   <= first_cnt;
            block_done <= 1'b0;
        end else if (datin_valid) begin
            word_cnt <= word_cnt - 1'b1;      // Wraps into the next block
            if (word_cnt == mode_cnt) begin
                access_mode <= datin_data[access_mode_lsb +: $bits(access_mode_t)];
            end
            if (word_cnt == '0) begin
                block_done <= 1'b1;
            end
        end
    end

endmodule : cmd6_capture

`default_nettype wire

/* hdl/spi_app_pkg.sv */
`default_nettype none

package spi_app_pkg;

    // ==================================================
    // Message and response framing
    // ==================================================
    localparam int msg_len  = 64;   // Bits after the start bit
    localparam int resp_len = 64;

    typedef logic [msg_len-1:0]  msg_t;
    typedef logic [resp_len-1:0] resp_t;

    // Type byte on top, argument below it
    localparam int msg_type_len = 8;
    localparam int msg_type_lsb = msg_len - msg_type_len;
    localparam int msg_arg_len  = msg_type_lsb;

    typedef enum logic [msg_type_len-1:0] {
        type_nop            = 8'h00,
        type_led_set        = 8'h01,
        type_echo           = 8'h80,
        type_dat_in_status  = 8'h82
    } msg_type_t;

    // Set in the type byte when the host expects an answer
    localparam int resp_flag_bit = 7;

    // ==================================================
    // Payload types
    // ==================================================
    typedef logic [3:0]  led_t;
    typedef logic [15:0] dat_word_t;
    typedef logic [3:0]  access_mode_t;

    // Layout of the data-in status response
    localparam int status_mode_lsb = 0;     // Access mode in bits 3..0
    localparam int status_done_bit = 4;     // Block done flag

    // CMD6 access-mode nibble inside its data word
    localparam int access_mode_lsb = 8;

endpackage : spi_app_pkg

`default_nettype wire

/* hdl/spi_app_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_app_top #(
    parameter int turnaround_cycles = 6,
    parameter int block_words       = 32,
    parameter int mode_word_index   = 8
) (
    input  wire logic                      sd_datInWrite_clk,
    input  wire logic                      spi_rst_,
    input  wire logic                      spi_data_in,
    output logic                           spi_data_out,
    output logic                           spi_data_out_en,
    input  wire logic                      datin_rst,
    input  wire logic                      datin_valid,
    input  wire spi_app_pkg::dat_word_t    datin_data,
    output spi_app_pkg::led_t              led
);
    import spi_app_pkg::*;

    // Command path
    logic         msg_valid;
    msg_t         msg;
    logic         resp_load;
    resp_t        resp;
    logic         tx_busy;

    // Data-in status
    access_mode_t access_mode;
    logic         block_done;

    // ==================================================
    // Command port
    // ==================================================
    spi_msg_rx msg_rx0 (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .tx_busy           (tx_busy),
        .msg_valid         (msg_valid),
        .msg               (msg)
    );

    spi_ctrl ctrl0 (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .msg_valid         (msg_valid),
        .msg               (msg),
        .access_mode       (access_mode),
        .block_done        (block_done),
        .resp_load         (resp_load),
        .resp              (resp),
        .led               (led)
    );

    spi_resp_tx #(
        .turnaround_cycles (turnaround_cycles)
    ) resp_tx0 (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .resp_load         (resp_load),
        .resp              (resp),
        .tx_busy           (tx_busy),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en)
    );

    // ==================================================
    // SD data-in monitor
    // ==================================================
    cmd6_capture #(
        .block_words       (block_words),
        .mode_word_index   (mode_word_index)
    ) cmd6_cap0 (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .datin_rst         (datin_rst),
        .datin_valid       (datin_valid),
        .datin_data        (datin_data),
        .access_mode       (access_mode),
        .block_done        (block_done)
    );

endmodule : spi_app_top

`default_nettype wire

/* hdl/spi_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl (
    input  wire logic                         sd_datInWrite_clk,
    input  wire logic                         spi_rst_,
    input  wire logic                         msg_valid,
    input  wire spi_app_pkg::msg_t            msg,
    input  wire spi_app_pkg::access_mode_t    access_mode,
    input  wire logic                         block_done,
    output logic                              resp_load,
    output spi_app_pkg::resp_t                resp,
    output spi_app_pkg::led_t                 led
);
    import spi_app_pkg::*;

    msg_type_t              msg_type;
    logic [msg_arg_len-1:0] msg_arg;
    logic                   wants_resp;   // Response flag of the type byte
    logic                   has_resp;     // Known response type
    logic                   led_write;
    resp_t                  next_resp;

    assign msg_type   = msg_type_t'(msg[msg_len-1:msg_type_lsb]);
    assign msg_arg    = msg[msg_arg_len-1:0];
    assign wants_resp = msg[msg_type_lsb + resp_flag_bit];

    // ==================================================
    // Message decode
    // ==================================================
    always_comb begin
        next_resp = '0;
        has_resp  = 1'b0;
        led_write = 1'b0;
        case (msg_type)
            type_nop: begin
                // Nothing to do
            end
            type_led_set: begin
                led_write = 1'b1;
            end
            type_echo: begin
                next_resp = resp_t'(msg_arg);     // Zero-extended
                has_resp  = 1'b1;
            end
            type_dat_in_status: begin
                next_resp[status_mode_lsb +: $bits(access_mode_t)] = access_mode;
                next_resp[status_done_bit] = block_done;
                has_resp  = 1'b1;
            end
            default: begin
                // Unknown types are dropped
            end
        endcase
    end

    // ==================================================
    // LED register and response strobe
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led       <= '0;
            resp_load <= 1'b0;
        end else begin
            resp_load <= msg_valid && wants_resp && has_resp;
            if (msg_valid && led_write) begin
                led <= msg_arg[$bits(led_t)-1:0];
            end
        end
    end

    // Response word, held until the transmitter latches it
    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid && has_resp) begin
            resp <= next_resp;
        end
    end

endmodule : spi_ctrl

`default_nettype wire

/* hdl/spi_msg_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_msg_rx (
    input  wire logic                sd_datInWrite_clk,
    input  wire logic                spi_rst_,
    input  wire logic                spi_data_in,
    input  wire logic                tx_busy,
    output logic                     msg_valid,
    output spi_app_pkg::msg_t        msg
);
    import spi_app_pkg::*;

    localparam int cnt_w = $clog2(msg_len);
    localparam logic [cnt_w-1:0] last_bit_cnt = cnt_w'(msg_len - 1);

    logic             receiving;
    logic [cnt_w-1:0] bit_cnt;    // Bits still to come, minus one

    // ==================================================
    // Start detection and bit counting
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (receiving) begin
                if (bit_cnt == '0) begin
                    receiving <= 1'b0;
                    msg_valid <= 1'b1;    // Same edge as the last bit
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end else if (spi_data_in && !tx_busy) begin
                // Line idles low, so the first 1 is the start bit
                receiving <= 1'b1;
                bit_cnt   <= last_bit_cnt;
            end
        end
    end

    // Message shift register, MSB first
    always_ff @(posedge sd_datInWrite_clk) begin
        if (receiving) begin
            msg <= {msg[msg_len-2:0], spi_data_in};
        end
    end

endmodule : spi_msg_rx

`default_nettype wire

/* hdl/spi_resp_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_resp_tx #(
    parameter int turnaround_cycles = 6
) (
    input  wire logic                 sd_datInWrite_clk,
    input  wire logic                 spi_rst_,
    input  wire logic                 resp_load,
    input  wire spi_app_pkg::resp_t   resp,
    output logic                      tx_busy,
    output logic                      spi_data_out,
    output logic                      spi_data_out_en
);
    import spi_app_pkg::*;

    localparam int cnt_max = (resp_len > turnaround_cycles) ? resp_len : turnaround_cycles;
    localparam int cnt_w   = $clog2(cnt_max);

    typedef enum logic [1:0] {
        st_idle,
        st_turn,    // Line released, host turns around
        st_send
    } tx_state_t;

    tx_state_t        state;
    logic [cnt_w-1:0] cnt;
    resp_t            shreg;

    // ==================================================
    // Turnaround and shift control
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (resp_load) begin
                        state <= st_turn;
                        cnt   <= cnt_w'(turnaround_cycles - 1);
                    end
                end
                st_turn: begin
                    if (cnt == '0) begin
                        state <= st_send;
                        cnt   <= cnt_w'(resp_len - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_send: begin
                    if (cnt == '0) begin
                        state <= st_idle;   // Last bit went out this cycle
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Response shift register
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == st_idle && resp_load) begin
            shreg <= resp;
        end else if (state == st_send) begin
            shreg <= {shreg[resp_len-2:0], 1'b0};
        end
    end

    assign spi_data_out    = shreg[resp_len-1];     // MSB first
    assign spi_data_out_en = (state == st_send);
    assign tx_busy         = resp_load || (state != st_idle);

endmodule : spi_resp_tx

`default_nettype wire

/* test/spi_app_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_app_assertions (
    input wire logic sd_datInWrite_clk,
    input wire logic spi_rst_,
    input wire logic spi_data_out_en,
    input wire logic msg_valid,
    input wire logic tx_busy
);
    import spi_app_pkg::*;

    int en_high_cnt;    // Edges the enable has been high in this burst
    int fail_cnt = 0;   // Assertion failures so far

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            en_high_cnt <= 0;
        end else if (spi_data_out_en) begin
            en_high_cnt <= en_high_cnt + 1;
        end else begin
            en_high_cnt <= 0;
        end
    end

    // ==================================================
    // Response framing
    // ==================================================
    a_quiet_in_reset: assert property (@(posedge sd_datInWrite_clk)
        !spi_rst_ |-> !spi_data_out_en)
        else begin
            $error("response enable high during reset");
            fail_cnt++;
        end

    a_burst_not_long: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        spi_data_out_en |-> (en_high_cnt < resp_len))
        else begin
            $error("response enable high for more than %0d cycles", resp_len);
            fail_cnt++;
        end

    a_burst_full: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        $fell(spi_data_out_en) |-> (en_high_cnt == resp_len))
        else begin
            $error("response burst ended after %0d cycles", en_high_cnt);
            fail_cnt++;
        end

    a_no_msg_during_tx: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        !(msg_valid && tx_busy))
        else begin
            $error("message accepted while a response was pending");
            fail_cnt++;
        end

endmodule : spi_app_assertions

bind spi_app_top spi_app_assertions assertions0 (
    .sd_datInWrite_clk (sd_datInWrite_clk),
    .spi_rst_          (spi_rst_),
    .spi_data_out_en   (spi_data_out_en),
    .msg_valid         (msg_valid),
    .tx_busy           (tx_busy)
);

`default_nettype wire

/* test/spi_app_vectors.txt */
# kind name arg(hex) expected(hex), one test per line
# E echo, L led set, N nop, B full block (arg = word 8), P short block, R reset
E echo_small 00000000000000a5 00000000000000a5
E echo_full 00ffffffffffffff 00ffffffffffffff
E echo_pattern 005a3c96e10f7b24 005a3c96e10f7b24
L led_set_9 0000000000000009 9
L led_set_5 00123456789abcd5 5
N nop_keeps_led 000000000000ffff 5
B block_full 0000000000000b00 000000000000001b
P block_short 0000000000000000 000000000000000b
B block_mode_3 000000000000f3ff 0000000000000013
P block_short_again 0000000000000000 0000000000000003
E echo_after_blocks 0000000000001234 0000000000001234
R reset_mid 0000000000000000 0000000000000000
L led_after_reset 000000000000000c c

/* test/tb_spi_app.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_app;
    import spi_app_pkg::*;

    localparam int clk_period        = 20;
    localparam int turnaround_cycles = 6;
    localparam int block_words       = 32;
    localparam int mode_word_index   = 8;
    localparam int short_block_words = 5;
    localparam int resp_wait_cycles  = 200;     // Timeout for a response to start
    localparam int quiet_cycles      = turnaround_cycles + 20;

    logic      sd_datInWrite_clk;
    logic      spi_rst_;
    logic      spi_data_in;
    logic      spi_data_out;
    logic      spi_data_out_en;
    logic      datin_rst;
    logic      datin_valid;
    dat_word_t datin_data;
    led_t      led;

    int errors;
    int tests;
    int failed_tests;

    spi_app_top #(
        .turnaround_cycles (turnaround_cycles),
        .block_words       (block_words),
        .mode_word_index   (mode_word_index)
    ) dut0 (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en),
        .datin_rst         (datin_rst),
        .datin_valid       (datin_valid),
        .datin_data        (datin_data),
        .led               (led)
    );

    initial sd_datInWrite_clk = 1'b0;
    always #(clk_period / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_resp(input string name, input resp_t expv, input resp_t actv);
        if (actv !== expv) begin
            $display("error: %s expected %h actual %h", name, expv, actv);
            errors++;
        end
    endtask

    task automatic check_led(input string name, input led_t expv, input led_t actv);
        if (actv !== expv) begin
            $display("error: %s expected %h actual %h", name, expv, actv);
            errors++;
        end
    endtask

    // ==================================================
    // Serial host side
    // ==================================================
    task automatic send_msg(input msg_t m);
        @(negedge sd_datInWrite_clk);
        spi_data_in = 1'b1;                 // Start bit
        for (int i = msg_len - 1; i >= 0; i--) begin
            @(negedge sd_datInWrite_clk);
            spi_data_in = m[i];
        end
        @(negedge sd_datInWrite_clk);
        spi_data_in = 1'b0;                 // Back to idle
    endtask

    task automatic recv_resp(input string name, output resp_t r, output bit ok);
        int waited;
        r = '0;
        ok = 1'b0;
        waited = 0;
        while (!spi_data_out_en && waited < resp_wait_cycles) begin
            @(negedge sd_datInWrite_clk);
            waited++;
        end
        if (!spi_data_out_en) begin
            $display("test %s: no response started within %0d cycles", name, resp_wait_cycles);
            errors++;
        end else begin
            // Sampled mid-cycle, MSB first
            for (int i = resp_len - 1; i >= 0; i--) begin
                r[i] = spi_data_out;
                if (i > 0) begin
                    @(negedge sd_datInWrite_clk);
                end
            end
            ok = 1'b1;
            waited = 0;
            while (spi_data_out_en && waited < 4) begin
                @(negedge sd_datInWrite_clk);
                waited++;
            end
            if (spi_data_out_en) begin
                $display("test %s: response enable stayed high after the last bit", name);
                errors++;
            end
        end
    endtask

    task automatic run_exchange(input string name, input msg_t m, input resp_t expv);
        resp_t r;
        bit    ok;
        send_msg(m);
        recv_resp(name, r, ok);
        if (ok) begin
            check_resp(name, expv, r);
        end
    endtask

    task automatic expect_quiet(input string name);
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge sd_datInWrite_clk);
            if (spi_data_out_en) begin
                $display("test %s: a response was driven where none belongs", name);
                errors++;
                break;
            end
        end
    endtask

    // Block start pulse, then one word per cycle
    task automatic send_block(input int n_words, input dat_word_t mode_word);
        @(negedge sd_datInWrite_clk);
        datin_rst = 1'b1;
        @(negedge sd_datInWrite_clk);
        datin_rst = 1'b0;
        for (int i = 0; i < n_words; i++) begin
            datin_valid = 1'b1;
            datin_data  = (i == mode_word_index) ? mode_word : dat_word_t'($urandom);
            @(negedge sd_datInWrite_clk);
        end
        datin_valid = 1'b0;
        datin_data  = '0;
    endtask

    // ==================================================
    // Vector driven sequence
    // ==================================================
    initial begin
        int               fd;
        int               n;
        int               errors_before;
        string            line;
        string            name;
        logic [7:0]       kind;
        logic [8*32-1:0]  name_buf;
        logic [63:0]      arg;
        logic [63:0]      expv;
        msg_t             m;

        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        void'($urandom(32'h3f72ee0f));

        spi_rst_    = 1'b0;
        spi_data_in = 1'b0;
        datin_rst   = 1'b0;
        datin_valid = 1'b0;
        datin_data  = '0;
        repeat (3) @(negedge sd_datInWrite_clk);
        spi_rst_ = 1'b1;

        fd = $fopen("test/spi_app_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file test/spi_app_vectors.txt");
            errors++;
        end

        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;                   // Blank or comment line
            end
            name_buf = '0;
            if ($sscanf(line, "%c %s %h %h", kind, name_buf, arg, expv) != 4) begin
                $display("malformed vector line: %s", line);
                errors++;
                continue;
            end
            name = string'(name_buf);
            errors_before = errors;
            tests++;
            case (kind)
                "E": begin
                    m = {type_echo, arg[msg_arg_len-1:0]};
                    run_exchange(name, m, resp_t'(expv));
                end
                "L", "N": begin
                    if (kind == "L") begin
                        m = {type_led_set, arg[msg_arg_len-1:0]};
                    end else begin
                        m = {type_nop, arg[msg_arg_len-1:0]};
                    end
                    send_msg(m);
                    expect_quiet(name);
                    check_led(name, led_t'(expv), led);
                end
                "B", "P": begin
                    send_block((kind == "B") ? block_words : short_block_words,
                               dat_word_t'(arg));
                    m = {type_dat_in_status, {msg_arg_len{1'b0}}};
                    run_exchange(name, m, resp_t'(expv));
                end
                "R": begin
                    @(negedge sd_datInWrite_clk);
                    spi_rst_ = 1'b0;
                    @(negedge sd_datInWrite_clk);
                    spi_rst_ = 1'b1;
                    @(negedge sd_datInWrite_clk);
                    check_led(name, led_t'(0), led);    // LED register clears on reset
                    m = {type_dat_in_status, {msg_arg_len{1'b0}}};
                    run_exchange(name, m, resp_t'(expv));
                end
                default: begin
                    $display("test %s: unknown vector kind %c", name, kind);
                    errors++;
                end
            endcase
            if (errors == errors_before) begin
                $display("test %s ok", name);
            end else begin
                $display("test %s failed", name);
                failed_tests++;
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests == 0) begin
            $display("no tests were read from the vector file");
            errors++;
        end
        if (dut0.assertions0.fail_cnt != 0) begin
            $display("%0d assertion failures were reported", dut0.assertions0.fail_cnt);
            errors += dut0.assertions0.fail_cnt;
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_spi_app

`default_nettype wire
